/* src/gpuPkg.sv */
package gpuPkg;

  //////////////////////////////////////////////////
  // micro-op encodings
  //////////////////////////////////////////////////

  typedef enum logic [3:0]
  {
    gNop,        // idle slot
    gWfBuffer,   // push converted row to framebuffer
    gIncFbAddr,  // step framebuffer address
    gWrr,        // move op1 into dst
    gWrl,        // literal into dst
    gRvmem,      // video memory read strobe
    gAdd,
    gAddl,       // dst + literal
    gSub,
    gSubl,       // dst - literal
    gAnd,
    gShl,        // op1 shifted by literal
    gJz,
    gJnz,
    gGoto
  } gpuOpE;

  // engine-visible registers, also used as destinations
  typedef enum logic [3:0]
  {
    rLcdc, rBgp, rMcuAddr, rBh, rBl, rCurTile, rR0, rR1
  } gpuRegE;

  // operand sources; first eight line up with gpuRegE
  typedef enum logic [4:0]
  {
    sLcdc, sBgp, sMcuAddr, sBh, sBl, sCurTile, sR0, sR1,
    sMapBase,   // tile map base from LCDC bit 6
    sTileBase,  // tile set base, signed set aware
    sVmemData,  // raw byte from video memory
    sVmemShl4,  // byte times 16, one tile = 16 bytes
    sZero
  } gpuSrcE;

  typedef enum logic [2:0]
  {
    hLcdc, hScy, hScx, hLyc, hBgp
  } hostRegE;

  //////////////////////////////////////////////////
  // microcode word
  //////////////////////////////////////////////////

  localparam int UopWidth = 24;
  localparam int LitWidth = 6;  // literal, also the jump target
  localparam int PcWidth  = 6;

  // msb first: op, dst, src0, src1, lit
  typedef struct packed
  {
    gpuOpE               op;
    gpuRegE              dst;
    gpuSrcE              src0;
    gpuSrcE              src1;
    logic [LitWidth-1:0] lit;
  } gpuUopT;

  //////////////////////////////////////////////////
  // memory map and LCDC bits
  //////////////////////////////////////////////////

  localparam logic [15:0] MapBase0     = 16'h9800;
  localparam logic [15:0] MapBase1     = 16'h9c00;
  localparam logic [15:0] TileSet1Base = 16'h8000;  // unsigned numbers
  localparam logic [15:0] TileSet0Base = 16'h9000;  // signed, 0..127
  localparam logic [15:0] TileSet0Neg  = 16'h8000;  // signed, -128..-1 lands at 8800

  localparam int LcdcEnableBit  = 7;
  localparam int LcdcMapBit     = 6;
  localparam int LcdcTileSetBit = 4;

endpackage

/* src/gpuUopIf.sv */
`timescale 1ns/10ps

// decoded micro-op, driven straight from the microcode ROM
interface gpuUopIf import gpuPkg::*; ();

  gpuOpE               op;
  gpuRegE              dst;
  gpuSrcE              src0;
  gpuSrcE              src1;
  logic [LitWidth-1:0] lit;  // literal or jump target

  modport seq
  (
    output op, dst, src0, src1, lit
  );

  modport alu
  (
    input op, lit
  );

  // op needed for the addl/subl operand swap
  modport regs
  (
    input op, dst, src0, src1
  );

endinterface

/* src/gpuSequencer.sv */
`timescale 1ns/10ps

module gpuSequencer import gpuPkg::*;
#(
  parameter int TileCount = 4
)
(
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] lcdc,
  input  logic       jump,
  gpuUopIf.seq       uop
);

  localparam int RomDepth = 16;
  localparam logic [PcWidth-1:0] LoopPc = 6'd2;   // top of per-tile loop
  localparam logic [PcWidth-1:0] HaltPc = 6'd15;  // self jump

  logic [PcWidth-1:0]  pc;
  logic [UopWidth-1:0] romWord;
  gpuUopT              word;
  logic                active;

  assign active = lcdc[LcdcEnableBit];

  //////////////////////////////////////////////////
  // program counter
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset || !active)
      pc <= '0;  // disabled engine restarts from 0
    else if (jump)
      pc <= uop.lit;
    else
      pc <= pc + 1'b1;
  end

  function automatic logic [UopWidth-1:0] uopWord(gpuOpE op, gpuRegE dst, gpuSrcE s0,
                                                  gpuSrcE s1, logic [LitWidth-1:0] lit);
    return {op, dst, s0, s1, lit};
  endfunction

  //////////////////////////////////////////////////
  // background microcode
  //////////////////////////////////////////////////

  always_comb
  begin
    case (pc)
      6'd0:  romWord = uopWord(gWrl, rR0, sZero, sZero, LitWidth'(TileCount));
      6'd1:  romWord = uopWord(gWrr, rCurTile, sZero, sZero, '0);       // start at tile 0
      6'd2:  romWord = uopWord(gAdd, rMcuAddr, sMapBase, sCurTile, '0); // map entry
      6'd3:  romWord = uopWord(gRvmem, rR1, sZero, sZero, '0);
      6'd4:  romWord = uopWord(gAdd, rMcuAddr, sTileBase, sVmemShl4, '0); // row 0 of tile
      6'd5:  romWord = uopWord(gRvmem, rR1, sZero, sZero, '0);
      6'd6:  romWord = uopWord(gWrr, rBl, sZero, sVmemData, '0);     // low plane
      6'd7:  romWord = uopWord(gAddl, rMcuAddr, sZero, sZero, 6'd1);
      6'd8:  romWord = uopWord(gRvmem, rR1, sZero, sZero, '0);
      6'd9:  romWord = uopWord(gWrr, rBh, sZero, sVmemData, '0);     // high plane
      6'd10: romWord = uopWord(gWfBuffer, rR1, sZero, sZero, '0);
      6'd11: romWord = uopWord(gIncFbAddr, rR1, sZero, sZero, '0);
      6'd12: romWord = uopWord(gAddl, rCurTile, sZero, sZero, 6'd1);
      6'd13: romWord = uopWord(gSubl, rR0, sZero, sZero, 6'd1);     // sets zero flag
      6'd14: romWord = uopWord(gJnz, rR1, sZero, sZero, LoopPc);
      default: romWord = uopWord(gGoto, rR1, sZero, sZero, HaltPc); // parked
    endcase
  end

  assign word = gpuUopT'(romWord);

  // idle engine issues nops so nothing moves before LCDC bit 7
  always_comb
  begin
    uop.op   = active ? word.op : gNop;
    uop.dst  = word.dst;
    uop.src0 = word.src0;
    uop.src1 = word.src1;
    uop.lit  = word.lit;
  end

  pcInRom: assert property (@(posedge clk) disable iff (reset) pc < RomDepth)
    else $error("sequencer pc left microcode ROM: %0d", pc);

endmodule

/* src/gpuRegFile.sv */
`timescale 1ns/10ps

module gpuRegFile import gpuPkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        hostWe,
  input  hostRegE     hostSel,
  input  logic [7:0]  hostData,
  input  logic [7:0]  mcuReadData,
  gpuUopIf.regs       uop,
  input  logic        regWe,
  input  logic [15:0] result,
  output logic [15:0] op0,
  output logic [15:0] op1,
  output logic [7:0]  lcdc,
  output logic [7:0]  scy,
  output logic [7:0]  scx,
  output logic [7:0]  lyc,
  output logic [7:0]  bgp,
  output logic [15:0] mcuAddr,
  output logic [7:0]  bh,
  output logic [7:0]  bl
);

  logic [15:0] curTile;
  logic [15:0] r0;       // tiles left
  logic [15:0] mapBase;
  logic [15:0] tileBase;
  gpuSrcE      op1Sel;

  //////////////////////////////////////////////////
  // register writes
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      lcdc    <= '0;
      scy     <= '0;
      scx     <= '0;
      lyc     <= '0;
      bgp     <= '0;
      mcuAddr <= '0;
      bh      <= '0;
      bl      <= '0;
      curTile <= '0;
      r0      <= '0;
    end
    else
    begin
      if (regWe)
      begin
        case (uop.dst)
          rLcdc:    lcdc    <= result[7:0];
          rBgp:     bgp     <= result[7:0];
          rMcuAddr: mcuAddr <= result;
          rBh:      bh      <= result[7:0];
          rBl:      bl      <= result[7:0];
          rCurTile: curTile <= result;
          rR0:      r0      <= result;
          default:  ;
        endcase
      end
      // host comes last, wins a same-cycle clash
      if (hostWe)
      begin
        case (hostSel)
          hLcdc:   lcdc <= hostData;
          hScy:    scy  <= hostData;  // host only
          hScx:    scx  <= hostData;  // host only
          hLyc:    lyc  <= hostData;  // host only
          hBgp:    bgp  <= hostData;
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // derived sources and operand muxes
  //////////////////////////////////////////////////

  assign mapBase = lcdc[LcdcMapBit] ? MapBase1 : MapBase0;

  // set 0 numbers are signed, bit 7 picks the 8800 half
  assign tileBase = lcdc[LcdcTileSetBit] ? TileSet1Base :
                    mcuReadData[7]       ? TileSet0Neg  : TileSet0Base;

  function automatic logic [15:0] srcMux(gpuSrcE sel);
    case (sel)
      sLcdc:     return {8'h00, lcdc};
      sBgp:      return {8'h00, bgp};
      sMcuAddr:  return mcuAddr;
      sBh:       return {8'h00, bh};
      sBl:       return {8'h00, bl};
      sCurTile:  return curTile;
      sR0:       return r0;
      sMapBase:  return mapBase;
      sTileBase: return tileBase;
      sVmemData: return {8'h00, mcuReadData};
      sVmemShl4: return {4'h0, mcuReadData, 4'h0};
      default:   return '0;  // sZero, also the unused R1 slot
    endcase
  endfunction

  // read-modify-write ops take op1 from their destination
  assign op1Sel = (uop.op == gAddl || uop.op == gSubl) ? gpuSrcE'({1'b0, uop.dst}) : uop.src1;

  assign op0 = srcMux(uop.src0);
  assign op1 = srcMux(op1Sel);

endmodule

/* src/gpuAlu.sv */
`timescale 1ns/10ps

module gpuAlu import gpuPkg::*;
(
  input  logic        clk,
  input  logic        reset,
  gpuUopIf.alu        uop,
  input  logic [15:0] op0,
  input  logic [15:0] op1,
  output logic [15:0] result,
  output logic        regWe,
  output logic        jump,
  output logic        fbWe,
  output logic        incFbAddr,
  output logic        mcuReadRequest
);

  logic [15:0] litExt;
  logic        zeroFlag;

  assign litExt = {{(16-LitWidth){1'b0}}, uop.lit};

  //////////////////////////////////////////////////
  // decode and compute
  //////////////////////////////////////////////////

  always_comb
  begin
    result         = op1;  // passthrough for non-writing ops
    regWe          = 1'b0;
    jump           = 1'b0;
    fbWe           = 1'b0;
    incFbAddr      = 1'b0;
    mcuReadRequest = 1'b0;
    case (uop.op)
      gWfBuffer:  fbWe = 1'b1;
      gIncFbAddr: incFbAddr = 1'b1;
      gRvmem:     mcuReadRequest = 1'b1;  // mcuAddr already latched
      gWrr:       regWe = 1'b1;
      gWrl:
      begin
        result = litExt;
        regWe  = 1'b1;
      end
      gAdd:
      begin
        result = op1 + op0;
        regWe  = 1'b1;
      end
      gAddl:
      begin
        result = op1 + litExt;
        regWe  = 1'b1;
      end
      gSub:
      begin
        result = op1 - op0;
        regWe  = 1'b1;
      end
      gSubl:
      begin
        result = op1 - litExt;  // loop counter decrement
        regWe  = 1'b1;
      end
      gAnd:
      begin
        result = op1 & op0;
        regWe  = 1'b1;
      end
      gShl:
      begin
        result = op1 << uop.lit[3:0];
        regWe  = 1'b1;
      end
      gJz:    jump = zeroFlag;
      gJnz:   jump = !zeroFlag;
      gGoto:  jump = 1'b1;
      default: ;  // gNop
    endcase
  end

  // zero flag follows every register write
  always_ff @(posedge clk)
  begin
    if (reset)
      zeroFlag <= 1'b0;
    else if (regWe)
      zeroFlag <= (result == 16'h0000);
  end

  oneStrobe: assert property (@(posedge clk) disable iff (reset)
    $onehot0({fbWe, incFbAddr, mcuReadRequest, regWe}))
    else $error("more than one ALU strobe active");

endmodule

/* src/gpuPixelPath.sv */
`timescale 1ns/10ps

module gpuPixelPath
(
  input  logic        clk,
  input  logic        reset,
  input  logic [7:0]  bh,
  input  logic [7:0]  bl,
  input  logic [7:0]  bgp,
  input  logic        fbWe,
  input  logic        incFbAddr,
  output logic [15:0] fbData,
  output logic [15:0] fbAddr
);

  //////////////////////////////////////////////////
  // palette conversion, 8 pixels side by side
  //////////////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < 8; i++)
    begin
      // color index = {high plane, low plane}
      fbData[2*i +: 2] = bgp[2*{bh[i], bl[i]} +: 2];
    end
  end

  // framebuffer word address
  always_ff @(posedge clk)
  begin
    if (reset)
      fbAddr <= '0;
    else if (incFbAddr)
      fbAddr <= fbAddr + 16'd1;
  end

  // address only steps right behind a write
  stepAfterWrite: assert property (@(posedge clk) disable iff (reset)
    incFbAddr |-> $past(fbWe))
    else $error("framebuffer address stepped without a write");

endmodule

/* src/gpu.sv */
`timescale 1ns/10ps

module gpu import gpuPkg::*;
#(
  parameter int TileCount = 4  // 1 to 63
)
(
  input  logic        clk,
  input  logic        reset,
  input  logic        hostWe,
  input  hostRegE     hostSel,
  input  logic [7:0]  hostData,
  input  logic [7:0]  mcuReadData,
  output logic        fbWe,
  output logic [15:0] fbData,
  output logic [15:0] fbAddr,
  output logic [15:0] mcuAddr,
  output logic        mcuReadRequest,
  output logic [7:0]  lcdc,
  output logic [7:0]  scy,
  output logic [7:0]  scx,
  output logic [7:0]  lyc,
  output logic [7:0]  bgp
);

  logic [15:0] op0;
  logic [15:0] op1;
  logic [15:0] result;
  logic        regWe;
  logic        jump;
  logic        incFbAddr;
  logic [7:0]  bh;  // tile row, high plane
  logic [7:0]  bl;  // tile row, low plane

  gpuUopIf uopBus();

  gpuSequencer #(.TileCount(TileCount)) u_sequencer
  (
    .clk(clk), .reset(reset), .lcdc(lcdc), .jump(jump), .uop(uopBus)
  );

  gpuRegFile u_regFile
  (
    .clk(clk), .reset(reset),
    .hostWe(hostWe), .hostSel(hostSel), .hostData(hostData),
    .mcuReadData(mcuReadData), .uop(uopBus), .regWe(regWe), .result(result),
    .op0(op0), .op1(op1),
    .lcdc(lcdc), .scy(scy), .scx(scx), .lyc(lyc), .bgp(bgp),
    .mcuAddr(mcuAddr), .bh(bh), .bl(bl)
  );

  gpuAlu u_alu
  (
    .clk(clk), .reset(reset), .uop(uopBus), .op0(op0), .op1(op1),
    .result(result), .regWe(regWe), .jump(jump), .fbWe(fbWe),
    .incFbAddr(incFbAddr), .mcuReadRequest(mcuReadRequest)
  );

  gpuPixelPath u_pixelPath
  (
    .clk(clk), .reset(reset), .bh(bh), .bl(bl), .bgp(bgp),
    .fbWe(fbWe), .incFbAddr(incFbAddr), .fbData(fbData), .fbAddr(fbAddr)
  );

endmodule

/* tests/gpuChecker.sv */
`timescale 1ns/10ps

module gpuChecker import gpuPkg::*;
#(
  parameter int TileCount = 4
)
(
  input  logic        clk,
  input  logic        reset,
  input  logic        hostWe,
  input  hostRegE     hostSel,
  input  logic [7:0]  hostData,
  input  logic        fbWe,
  input  logic [15:0] fbData,
  input  logic [15:0] fbAddr,
  input  logic [15:0] mcuAddr,
  input  logic        mcuReadRequest,
  input  logic [7:0]  lcdc,
  input  logic [7:0]  scy,
  input  logic [7:0]  scx,
  input  logic [7:0]  lyc,
  input  logic [7:0]  bgp,
  input  logic [7:0]  vmem [65536],  // same image the memory model serves
  input  logic        testEnd,
  input  int          testNum,
  input  logic        allDone,
  output int          runWords,      // words since the engine last restarted
  output int          errorCount
);

  // host register shadows, updated from the host port
  logic [7:0]  expLcdc;
  logic [7:0]  expScy;
  logic [7:0]  expScx;
  logic [7:0]  expLyc;
  logic [7:0]  expBgp;
  logic [15:0] expWord;
  logic [15:0] expAddr;
  int          readIdx;        // video memory reads within the current tile
  int          totalWords;     // also the expected framebuffer address
  int          testCount;
  int          wordsAtStart;
  int          errorsAtStart;

  function automatic string testTitle(int n);
    case (n)
      1:       return "idle after reset";
      2:       return "host registers";
      3:       return "map 9c00, unsigned set";
      4:       return "map 9800, signed set";
      5:       return "restart with new palette";
      default: return "unnamed";
    endcase
  endfunction

  //////////////////////////////////////////////////
  // reference model of one background row
  //////////////////////////////////////////////////

  // set 0 takes the tile number as two's complement around 9000
  function automatic logic [15:0] rowAddr(logic [7:0] tileNum, logic unsignedSet);
    if (unsignedSet)
      return 16'h8000 + {4'h0, tileNum, 4'h0};
    return 16'h9000 + {{4{tileNum[7]}}, tileNum, 4'h0};
  endfunction

  // reads per tile: map entry, then low plane, then high plane
  function automatic logic [15:0] expectedAddr(int tileIdx, int readNum, logic [7:0] lcdcVal);
    logic [15:0] mapAddr;
    logic [15:0] row;
    mapAddr = (lcdcVal[6] ? 16'h9c00 : 16'h9800) + 16'(tileIdx);
    row     = rowAddr(vmem[mapAddr], lcdcVal[4]);
    if (readNum == 0)
      return mapAddr;
    return (readNum == 1) ? row : row + 16'd1;  // high plane follows the low one
  endfunction

  function automatic logic [15:0] expectedWord(int tileIdx, logic [7:0] lcdcVal,
                                               logic [7:0] pal);
    logic [7:0]  lo;
    logic [7:0]  hi;
    logic [7:0]  shade;
    logic [15:0] word;
    lo = vmem[expectedAddr(tileIdx, 1, lcdcVal)];
    hi = vmem[expectedAddr(tileIdx, 2, lcdcVal)];
    for (int i = 0; i < 8; i++)
    begin
      shade = pal >> {hi[i], lo[i], 1'b0};  // palette entry n sits at bits 2n+1:2n
      word[2*i +: 2] = shade[1:0];
    end
    return word;
  endfunction

  task automatic checkReg(string name, logic [7:0] got, logic [7:0] exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0d ns: %s reads %h, expected %h", $time, name, got, exp);
      errorCount++;
    end
  endtask

  //////////////////////////////////////////////////
  // per-cycle monitor
  //////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (reset)
    begin
      expLcdc <= '0;
      expScy  <= '0;
      expScx  <= '0;
      expLyc  <= '0;
      expBgp  <= '0;
      runWords      = 0;
      errorCount    = 0;
      readIdx       = 0;
      totalWords    = 0;
      testCount     = 0;
      wordsAtStart  = 0;
      errorsAtStart = 0;
    end
    else
    begin
      checkReg("LCDC", lcdc, expLcdc);  // host writes land one cycle later
      checkReg("SCY", scy, expScy);
      checkReg("SCX", scx, expScx);
      checkReg("LYC", lyc, expLyc);
      checkReg("BGP", bgp, expBgp);
      if (!expLcdc[LcdcEnableBit] && (fbWe || mcuReadRequest))
      begin
        $display("%0d ns: engine strobed a write or read while disabled", $time);
        errorCount++;
      end
      if (mcuReadRequest)
      begin
        if (readIdx > 2)
        begin
          $display("%0d ns: more than three video memory reads for one tile", $time);
          errorCount++;
        end
        else
        begin
          expAddr = expectedAddr(runWords, readIdx, expLcdc);
          if (mcuAddr !== expAddr)
          begin
            $display("[FAIL] %0d ns: tile %0d read %0d at %h, expected %h",
                     $time, runWords, readIdx, mcuAddr, expAddr);
            errorCount++;
          end
        end
        readIdx++;
      end
      if (fbWe)
      begin
        if (runWords >= TileCount)
        begin
          $display("%0d ns: framebuffer written after the last tile of the run", $time);
          errorCount++;
        end
        else
        begin
          expWord = expectedWord(runWords, expLcdc, expBgp);
          if (fbData !== expWord)
          begin
            $display("[FAIL] %0d ns: tile %0d word %h, expected %h",
                     $time, runWords, fbData, expWord);
            errorCount++;
          end
          if (fbAddr !== 16'(totalWords))
          begin
            $display("[FAIL] %0d ns: address %h, expected %h", $time, fbAddr, 16'(totalWords));
            errorCount++;
          end
        end
        runWords++;
        totalWords++;
        readIdx = 0;  // next tile starts with its map read
      end
      if (!expLcdc[LcdcEnableBit])
      begin
        runWords = 0;  // engine restarts at tile 0
        readIdx  = 0;
      end
      if (hostWe)
      begin
        case (hostSel)
          hLcdc:   expLcdc <= hostData;
          hScy:    expScy  <= hostData;
          hScx:    expScx  <= hostData;
          hLyc:    expLyc  <= hostData;
          hBgp:    expBgp  <= hostData;
          default: ;
        endcase
      end
      if (testEnd)
      begin
        $display("test %0d %s: %0d words, %0d errors", testNum, testTitle(testNum),
                 totalWords - wordsAtStart, errorCount - errorsAtStart);
        testCount++;
        wordsAtStart  = totalWords;
        errorsAtStart = errorCount;
      end
      if (allDone)
        $display("totals: %0d tests, %0d words, %0d errors", testCount, totalWords, errorCount);
    end
  end

endmodule

/* tests/gpuTb.sv */
`timescale 1ns/10ps

module gpuTb import gpuPkg::*;
();

  localparam int TileCount   = 4;
  localparam int ClkPeriod   = 10;
  localparam int QuietCycles = 40;  // window that must stay free of writes after a run

  typedef enum logic [1:0] { kWrite, kIdle, kRun, kEnd } stepKindE;

  // arg is write data, idle cycles, expected words or test number
  typedef struct packed
  {
    stepKindE   kind;
    hostRegE    sel;
    logic [7:0] arg;
  } stepT;

  logic        clk = 1'b0;
  logic        reset;
  logic        hostWe;
  hostRegE     hostSel;
  logic [7:0]  hostData;
  logic [7:0]  mcuReadData = '0;
  logic        fbWe;
  logic [15:0] fbData;
  logic [15:0] fbAddr;
  logic [15:0] mcuAddr;
  logic        mcuReadRequest;
  logic [7:0]  lcdc;
  logic [7:0]  scy;
  logic [7:0]  scx;
  logic [7:0]  lyc;
  logic [7:0]  bgp;
  logic        testEnd;
  int          testNum;
  logic        allDone;
  int          runWords;
  int          errorCount;
  logic [7:0]  vmem [65536];
  stepT        steps [$];
  int          numRows = 0;
  int          seed = 32'hffac463b;

  always #(ClkPeriod / 2) clk = ~clk;

  gpu #(.TileCount(TileCount)) u_gpu
  (
    .clk(clk), .reset(reset), .hostWe(hostWe), .hostSel(hostSel), .hostData(hostData),
    .mcuReadData(mcuReadData), .fbWe(fbWe), .fbData(fbData), .fbAddr(fbAddr),
    .mcuAddr(mcuAddr), .mcuReadRequest(mcuReadRequest),
    .lcdc(lcdc), .scy(scy), .scx(scx), .lyc(lyc), .bgp(bgp)
  );

  gpuChecker #(.TileCount(TileCount)) u_checker
  (
    .clk(clk), .reset(reset), .hostWe(hostWe), .hostSel(hostSel), .hostData(hostData),
    .fbWe(fbWe), .fbData(fbData), .fbAddr(fbAddr), .mcuAddr(mcuAddr),
    .mcuReadRequest(mcuReadRequest),
    .lcdc(lcdc), .scy(scy), .scx(scx), .lyc(lyc), .bgp(bgp), .vmem(vmem),
    .testEnd(testEnd), .testNum(testNum), .allDone(allDone),
    .runWords(runWords), .errorCount(errorCount)
  );

  // video memory, data valid from the falling edge of the read strobe
  always @(negedge clk)
  begin
    if (mcuReadRequest)
      mcuReadData <= vmem[mcuAddr];
  end

  //////////////////////////////////////////////////
  // memory image and stimulus table
  //////////////////////////////////////////////////

  task automatic fillMemory();
    for (int a = 0; a < 65536; a++)
      vmem[a] = 8'($random(seed));
    for (int i = 0; i < 64; i++)
    begin
      vmem[16'h9800 + i] = i[0] ? 8'h90 + 8'(i) : 8'h10 + 8'(i);  // both halves of set 0
      vmem[16'h9c00 + i] = 8'(i * 8'h43);
    end
  endtask

  task automatic addStep(stepKindE kind, hostRegE sel, logic [7:0] arg);
    steps.push_back('{kind, sel, arg});
  endtask

  task automatic buildTable();
    addStep(kIdle, hLcdc, 8'd20);  // engine parked after reset
    addStep(kEnd, hLcdc, 8'd1);
    addStep(kWrite, hScy, 8'h12);
    addStep(kWrite, hScx, 8'h34);
    addStep(kWrite, hLyc, 8'h56);
    addStep(kWrite, hBgp, 8'he4);
    addStep(kWrite, hLcdc, 8'h50);  // bits 6 and 4, still stopped
    addStep(kIdle, hLcdc, 8'd4);
    addStep(kEnd, hLcdc, 8'd2);
    addStep(kWrite, hLcdc, 8'hd0);  // start, map 9c00, unsigned set
    addStep(kRun, hLcdc, 8'(TileCount));
    addStep(kEnd, hLcdc, 8'd3);
    addStep(kWrite, hLcdc, 8'h00);
    addStep(kWrite, hLcdc, 8'h80);  // map 9800, signed set
    addStep(kRun, hLcdc, 8'(TileCount));
    addStep(kEnd, hLcdc, 8'd4);
    addStep(kWrite, hBgp, 8'h1b);   // inverted palette
    addStep(kWrite, hLcdc, 8'h40);
    addStep(kWrite, hLcdc, 8'hc0);
    addStep(kRun, hLcdc, 8'(TileCount));
    addStep(kEnd, hLcdc, 8'd5);
  endtask

  // entered and left on a falling edge
  task automatic applyStep(stepT s);
    case (s.kind)
      kWrite:
      begin
        hostWe   = 1'b1;
        hostSel  = s.sel;
        hostData = s.arg;
        @(negedge clk);
        hostWe   = 1'b0;
      end
      kIdle:
        repeat (s.arg) @(negedge clk);
      kRun:
      begin
        while (runWords < int'(s.arg))
          @(negedge clk);
        repeat (QuietCycles) @(negedge clk);
      end
      default:
      begin
        testNum = int'(s.arg);
        testEnd = 1'b1;
        @(negedge clk);
        testEnd = 1'b0;
      end
    endcase
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////

  initial
  begin
    reset    = 1'b1;
    hostWe   = 1'b0;
    hostSel  = hLcdc;
    hostData = '0;
    testEnd  = 1'b0;
    testNum  = 0;
    allDone  = 1'b0;
    fillMemory();
    buildTable();
    numRows = steps.size();
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    foreach (steps[i])
      applyStep(steps[i]);
    allDone = 1'b1;  // checker prints the totals
    @(negedge clk);
    allDone = 1'b0;
    @(negedge clk);
    if (errorCount == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  initial
  begin
    wait (numRows > 0);
    repeat (numRows * 40 * TileCount) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not complete",
             numRows * 40 * TileCount);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* all.f */
src/gpuPkg.sv
src/gpuUopIf.sv
src/gpuSequencer.sv
src/gpuRegFile.sv
src/gpuAlu.sv
src/gpuPixelPath.sv
src/gpu.sv
tests/gpuChecker.sv
tests/gpuTb.sv

/* Makefile */
# Verilator simulation of the background renderer testbench

VERILATOR ?= verilator
FILELIST  ?= all.f
TOP       ?= gpuTb
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN     := $(BUILD_DIR)/$(TOP)
SOURCES := $(wildcard src/*.sv tests/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR FILELIST TOP BUILD_DIR LOG VFLAGS"

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

test: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "test failed, see $(LOG)"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "run ended early, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
